//--- hdl/mips_isa_pkg.sv
package mips_isa_pkg;

	// ============================================================
	// register file and data memory geometry
	// ============================================================
	localparam int REG_IDX_W  = 5;
	localparam int DMEM_WORDS = 256;
	// word address width into the data memory
	localparam int DMEM_AW    = $clog2(DMEM_WORDS);

	// ============================================================
	// encodings
	// ============================================================
	typedef enum logic [3:0] {
		MEM_NONE = 4'd0,
		MEM_LB   = 4'd1,
		MEM_LBU  = 4'd2,
		MEM_LH   = 4'd3,
		MEM_LHU  = 4'd4,
		MEM_LW   = 4'd5,
		MEM_SB   = 4'd6,
		MEM_SH   = 4'd7,
		MEM_SW   = 4'd8
	} mem_op_e;

	typedef enum logic [1:0] {
		RES_ALU = 2'd0,
		RES_PC8 = 2'd1,
		RES_HI  = 2'd2,
		RES_LO  = 2'd3
	} res_sel_e;

	// mult writes both halves, mthi/mtlo only one
	typedef enum logic [1:0] {
		HILO_NONE = 2'd0,
		HILO_MULT = 2'd1,
		HILO_MTHI = 2'd2,
		HILO_MTLO = 2'd3
	} hilo_wr_e;

	// loaded word, lane 0 is the lowest byte address
	typedef union packed {
		logic [3:0][7:0]  bytes;
		logic [1:0][15:0] halves;
	} load_word_u;

endpackage

//--- hdl/mips_pipe_pkg.sv
package mips_pipe_pkg;

	import mips_isa_pkg::*;

	// ============================================================
	// EX/MEM bundle
	// ============================================================
	typedef struct packed {
		logic [31:0]          pc4;
		logic [31:0]          alu_res;
		logic [31:0]          store_data;
		// {hi, lo} from the multiplier, or the mthi/mtlo operand
		logic [63:0]          hilo_wdata;
		logic [REG_IDX_W-1:0] rt;
		logic [REG_IDX_W-1:0] dest;
		mem_op_e              mem_op;
		res_sel_e             res_sel;
		hilo_wr_e             hilo_wr;
		logic                 regwrite;
	} ex_mem_t;

	// ============================================================
	// MEM/WB register contents
	// ============================================================
	typedef struct packed {
		logic [31:0]          result;
		logic [31:0]          memout;
		logic [1:0]           byte_off;
		mem_op_e              mem_op;
		logic [REG_IDX_W-1:0] dest;
		logic                 regwrite;
		logic                 is_load;
	} mem_wb_t;

	// register file write port
	typedef struct packed {
		logic                 we;
		logic [REG_IDX_W-1:0] waddr;
		logic [31:0]          wdata;
	} wb_port_t;

	// load in WB, for the upstream hazard unit
	typedef struct packed {
		logic                 valid;
		logic [REG_IDX_W-1:0] rt;
	} load_hazard_t;

endpackage

//--- hdl/mem_ctrl.sv
`timescale 1ns/100ps

module mem_ctrl
	import mips_isa_pkg::*, mips_pipe_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_nrst,
	input  ex_mem_t            i_ex_mem,
	input  wb_port_t           i_wb,
	output logic [DMEM_AW-1:0] o_waddr,
	output logic [3:0]         o_be,
	output logic [31:0]        o_wdata
);

	logic [1:0]  off;
	logic        is_store;
	logic        fwd_hit;
	logic [31:0] st_data;

	assign off      = i_ex_mem.alu_res[1:0];
	assign o_waddr  = i_ex_mem.alu_res[DMEM_AW+1:2];
	assign is_store = i_ex_mem.mem_op inside {MEM_SB, MEM_SH, MEM_SW};

	// load result sitting in WB feeds a store of the same register
	assign fwd_hit = is_store && i_wb.we && (i_wb.waddr == i_ex_mem.rt)
		&& (i_ex_mem.rt != '0);
	assign st_data = fwd_hit ? i_wb.wdata : i_ex_mem.store_data;

	// byte enables and lane placement
	always_comb begin
		o_be    = 4'b0000;
		o_wdata = st_data;
		case (i_ex_mem.mem_op)
			MEM_SB: begin
				o_be    = 4'b0001 << off;
				o_wdata = {4{st_data[7:0]}};
			end
			MEM_SH: begin
				o_be    = off[1] ? 4'b1100 : 4'b0011;
				o_wdata = {2{st_data[15:0]}};
			end
			MEM_SW: begin
				o_be = 4'b1111;
			end
			default: begin
				o_be = 4'b0000;
			end
		endcase
	end

	// ============================================================
	// alignment checks
	// ============================================================
	a_half_align: assert property (@(posedge i_clk) disable iff (!i_nrst)
		(i_ex_mem.mem_op inside {MEM_LH, MEM_LHU, MEM_SH}) |-> (off[0] == 1'b0))
		else $error("misaligned halfword access at %h", i_ex_mem.alu_res);

	a_word_align: assert property (@(posedge i_clk) disable iff (!i_nrst)
		(i_ex_mem.mem_op inside {MEM_LW, MEM_SW}) |-> (off == 2'b00))
		else $error("misaligned word access at %h", i_ex_mem.alu_res);

endmodule

//--- hdl/data_mem.sv
`timescale 1ns/100ps

module data_mem
	import mips_isa_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_nrst,
	input  logic [DMEM_AW-1:0] i_addr,
	input  logic [3:0]         i_be,
	input  logic [31:0]        i_wdata,
	output logic [31:0]        o_rdata
);

	logic [31:0] mem_q [DMEM_WORDS];

	// byte-lane writes, whole array cleared on reset
	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			for (int i = 0; i < DMEM_WORDS; i++) begin
				mem_q[i] <= '0;
			end
		end else begin
			for (int b = 0; b < 4; b++) begin
				if (i_be[b]) begin
					mem_q[i_addr][8*b +: 8] <= i_wdata[8*b +: 8];
				end
			end
		end
	end

	// combinational read
	assign o_rdata = mem_q[i_addr];

endmodule

//--- hdl/mem_stage.sv
`timescale 1ns/100ps

module mem_stage
	import mips_isa_pkg::*, mips_pipe_pkg::*;
(
	input  logic         i_clk,
	input  logic         i_nrst,
	input  ex_mem_t      i_ex_mem,
	input  logic [31:0]  i_memout,
	output mem_wb_t      o_mem_wb,
	output load_hazard_t o_load_hazard
);

	logic [31:0]          pc8;
	logic [31:0]          result;
	logic [31:0]          hi_q;
	logic [31:0]          lo_q;
	logic                 is_load;
	mem_wb_t              mem_wb_q;
	logic [REG_IDX_W-1:0] rt_q;

	assign pc8     = i_ex_mem.pc4 + 32'd4;
	assign is_load = i_ex_mem.mem_op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};

	// result select, mfhi/mflo read the registered values
	always_comb begin
		case (i_ex_mem.res_sel)
			RES_PC8: result = pc8;
			RES_HI:  result = hi_q;
			RES_LO:  result = lo_q;
			default: result = i_ex_mem.alu_res;
		endcase
	end

	// ============================================================
	// HI/LO
	// ============================================================
	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			hi_q <= '0;
			lo_q <= '0;
		end else begin
			case (i_ex_mem.hilo_wr)
				HILO_MULT: begin
					hi_q <= i_ex_mem.hilo_wdata[63:32];
					lo_q <= i_ex_mem.hilo_wdata[31:0];
				end
				// mthi/mtlo operand rides in the low half
				HILO_MTHI: hi_q <= i_ex_mem.hilo_wdata[31:0];
				HILO_MTLO: lo_q <= i_ex_mem.hilo_wdata[31:0];
				default: ;
			endcase
		end
	end

	// ============================================================
	// MEM/WB register
	// ============================================================
	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			mem_wb_q <= '0;
			rt_q     <= '0;
		end else begin
			mem_wb_q.result   <= result;
			mem_wb_q.memout   <= i_memout;
			mem_wb_q.byte_off <= i_ex_mem.alu_res[1:0];
			mem_wb_q.mem_op   <= i_ex_mem.mem_op;
			mem_wb_q.dest     <= i_ex_mem.dest;
			mem_wb_q.regwrite <= i_ex_mem.regwrite;
			mem_wb_q.is_load  <= is_load;
			rt_q              <= i_ex_mem.rt;
		end
	end

	assign o_mem_wb            = mem_wb_q;
	assign o_load_hazard.valid = mem_wb_q.is_load;
	assign o_load_hazard.rt    = rt_q;

endmodule

//--- hdl/wb_stage.sv
`timescale 1ns/100ps

module wb_stage
	import mips_isa_pkg::*, mips_pipe_pkg::*;
(
	input  mem_wb_t  i_mem_wb,
	output wb_port_t o_wb
);

	load_word_u  word;
	logic [7:0]  ld_byte;
	logic [15:0] ld_half;
	logic [31:0] ld_val;

	assign word    = i_mem_wb.memout;
	assign ld_byte = word.bytes[i_mem_wb.byte_off];
	assign ld_half = word.halves[i_mem_wb.byte_off[1]];

	// sign or zero extension by load kind
	always_comb begin
		case (i_mem_wb.mem_op)
			MEM_LB:  ld_val = {{24{ld_byte[7]}}, ld_byte};
			MEM_LBU: ld_val = {24'd0, ld_byte};
			MEM_LH:  ld_val = {{16{ld_half[15]}}, ld_half};
			MEM_LHU: ld_val = {16'd0, ld_half};
			default: ld_val = word.bytes;
		endcase
	end

	// ============================================================
	// register file write port
	// ============================================================
	// r0 is never written
	assign o_wb.we    = i_mem_wb.regwrite && (i_mem_wb.dest != '0);
	assign o_wb.waddr = i_mem_wb.dest;
	assign o_wb.wdata = i_mem_wb.is_load ? ld_val : i_mem_wb.result;

endmodule

//--- hdl/mem_wb_top.sv
`timescale 1ns/100ps

module mem_wb_top
	import mips_isa_pkg::*, mips_pipe_pkg::*;
(
	input  logic         i_clk,
	input  logic         i_nrst,
	input  ex_mem_t      i_ex_mem,
	output wb_port_t     o_wb,
	output load_hazard_t o_load_hazard
);

	logic [DMEM_AW-1:0] dm_addr;
	logic [3:0]         dm_be;
	logic [31:0]        dm_wdata;
	logic [31:0]        dm_rdata;
	mem_wb_t            mem_wb;

	// write port is fed back for store-data forwarding
	mem_ctrl u_mem_ctrl (
		.i_clk    (i_clk),
		.i_nrst   (i_nrst),
		.i_ex_mem (i_ex_mem),
		.i_wb     (o_wb),
		.o_waddr  (dm_addr),
		.o_be     (dm_be),
		.o_wdata  (dm_wdata)
	);

	data_mem u_data_mem (
		.i_clk   (i_clk),
		.i_nrst  (i_nrst),
		.i_addr  (dm_addr),
		.i_be    (dm_be),
		.i_wdata (dm_wdata),
		.o_rdata (dm_rdata)
	);

	mem_stage u_mem_stage (
		.i_clk         (i_clk),
		.i_nrst        (i_nrst),
		.i_ex_mem      (i_ex_mem),
		.i_memout      (dm_rdata),
		.o_mem_wb      (mem_wb),
		.o_load_hazard (o_load_hazard)
	);

	wb_stage u_wb_stage (
		.i_mem_wb (mem_wb),
		.o_wb     (o_wb)
	);

endmodule

//--- verification/tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen (
	output logic o_clk,
	output logic o_nrst
);

	localparam realtime HALF_PERIOD = 10.0;
	localparam int      RST_CYCLES  = 4;

	initial begin
		o_clk = 1'b0;
		forever #(HALF_PERIOD) o_clk = ~o_clk;
	end

	// reset held low for a few rising edges
	initial begin
		o_nrst = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		o_nrst <= 1'b1;
	end

endmodule

//--- verification/tb_checker.sv
`timescale 1ns/100ps

module tb_checker
	import mips_isa_pkg::*, mips_pipe_pkg::*;
(
	input  logic         i_clk,
	input  logic         i_nrst,
	input  wb_port_t     i_wb,
	input  load_hazard_t i_load_hazard,
	input  logic         i_exp_valid,
	input  logic [7:0]   i_grp,
	input  wb_port_t     i_exp_wb,
	input  load_hazard_t i_exp_hz,
	input  logic         i_done,
	output int           o_errors,
	output int           o_checks
);

	logic         q_valid;
	logic [7:0]   q_grp;
	wb_port_t     q_wb;
	load_hazard_t q_hz;
	logic [7:0]   cur_grp;
	int           grp_checks;
	int           grp_errs;
	int           total_checks;
	int           total_errs;
	logic         finished;

	initial begin
		cur_grp      = 8'd0;
		grp_checks   = 0;
		grp_errs     = 0;
		total_checks = 0;
		total_errs   = 0;
		finished     = 1'b0;
	end

	assign o_errors = total_errs;
	assign o_checks = total_checks;

	function automatic string group_name(input logic [7:0] g);
		case (g)
			8'd0:    return "reset";
			8'd1:    return "result select";
			8'd2:    return "hi/lo";
			8'd3:    return "stores and loads";
			8'd4:    return "store forwarding";
			8'd5:    return "load hazard";
			default: return "unknown";
		endcase
	endfunction

	task automatic compare_value(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		grp_checks++;
		total_checks++;
		if (got !== exp) begin
			grp_errs++;
			total_errs++;
			$display("CHECK FAILED %s exp %h got %h at %0t", name, exp, got, $time);
		end
	endtask

	task automatic report_group();
		$display("group %0d (%s): %0d checks, %0d errors", cur_grp, group_name(cur_grp),
			grp_checks, grp_errs);
	endtask

	// expected values of the bundle the DUT samples on this edge
	always @(posedge i_clk) begin
		q_valid <= i_exp_valid;
		q_grp   <= i_grp;
		q_wb    <= i_exp_wb;
		q_hz    <= i_exp_hz;
	end

	// ============================================================
	// compare at the falling edge, outputs are settled
	// ============================================================
	always @(negedge i_clk) begin
		if (!i_nrst) begin
			compare_value("o_wb.we", 32'(1'b0), 32'(i_wb.we));
			compare_value("o_load_hazard.valid", 32'(1'b0), 32'(i_load_hazard.valid));
		end else if (q_valid === 1'b1) begin
			if (q_grp != cur_grp) begin
				report_group();
				cur_grp    = q_grp;
				grp_checks = 0;
				grp_errs   = 0;
			end
			compare_value("o_wb.we", 32'(q_wb.we), 32'(i_wb.we));
			// address and data matter only when the port writes
			if (q_wb.we) begin
				compare_value("o_wb.waddr", 32'(q_wb.waddr), 32'(i_wb.waddr));
				compare_value("o_wb.wdata", q_wb.wdata, i_wb.wdata);
			end
			compare_value("o_load_hazard.valid", 32'(q_hz.valid), 32'(i_load_hazard.valid));
			if (q_hz.valid) begin
				compare_value("o_load_hazard.rt", 32'(q_hz.rt), 32'(i_load_hazard.rt));
			end
		end
		if (i_done && !finished) begin
			report_group();
			$display("checks %0d, errors %0d", total_checks, total_errs);
			finished = 1'b1;
		end
	end

endmodule

//--- verification/tb_top.sv
`timescale 1ns/100ps

module tb_top
	import mips_isa_pkg::*, mips_pipe_pkg::*;
();

	localparam int MAX_ROWS  = 64;
	localparam int RST_LIMIT = 50;

	logic         clk;
	logic         nrst;
	ex_mem_t      ex_mem;
	wb_port_t     wb;
	load_hazard_t hz;
	logic         exp_valid;
	logic [7:0]   grp;
	wb_port_t     exp_wb;
	load_hazard_t exp_hz;
	logic         done;
	int           errors;
	int           checks;
	logic [255:0] vec_mem [MAX_ROWS];

	tb_clkgen u_clkgen (
		.o_clk  (clk),
		.o_nrst (nrst)
	);

	mem_wb_top i_dut (
		.i_clk         (clk),
		.i_nrst        (nrst),
		.i_ex_mem      (ex_mem),
		.o_wb          (wb),
		.o_load_hazard (hz)
	);

	tb_checker u_checker (
		.i_clk         (clk),
		.i_nrst        (nrst),
		.i_wb          (wb),
		.i_load_hazard (hz),
		.i_exp_valid   (exp_valid),
		.i_grp         (grp),
		.i_exp_wb      (exp_wb),
		.i_exp_hz      (exp_hz),
		.i_done        (done),
		.o_errors      (errors),
		.o_checks      (checks)
	);

	initial begin
		logic [255:0] row;
		ex_mem_t      stim;
		int           wait_cnt;
		int           idx;

		ex_mem    = '0;
		exp_valid = 1'b0;
		grp       = 8'd0;
		exp_wb    = '0;
		exp_hz    = '0;
		done      = 1'b0;
		// unread rows look like the end marker
		for (int i = 0; i < MAX_ROWS; i++) begin
			vec_mem[i] = {8'hff, 248'd0};
		end
		$readmemh("verification/mem_wb_testdata.txt", vec_mem);

		wait_cnt = 0;
		while (nrst !== 1'b1 && wait_cnt < RST_LIMIT) begin
			@(posedge clk);
			wait_cnt++;
		end
		if (nrst !== 1'b1) begin
			$display("reset was not released within %0d cycles", RST_LIMIT);
			$display("TEST RESULT: FAIL");
			$finish;
		end else begin
			// ============================================================
			// one file row per clock
			// ============================================================
			idx = 0;
			while (idx < MAX_ROWS && vec_mem[idx][255:248] != 8'hff) begin
				row             = vec_mem[idx];
				stim.pc4        = row[247:216];
				stim.alu_res    = row[215:184];
				stim.store_data = row[183:152];
				stim.hilo_wdata = row[151:88];
				stim.rt         = row[84:80];
				stim.dest       = row[76:72];
				stim.mem_op     = mem_op_e'(row[71:68]);
				stim.res_sel    = res_sel_e'(row[65:64]);
				stim.hilo_wr    = hilo_wr_e'(row[61:60]);
				stim.regwrite   = row[56];
				@(posedge clk);
				ex_mem       <= stim;
				grp          <= row[255:248];
				exp_valid    <= 1'b1;
				exp_wb.we    <= row[52];
				exp_wb.waddr <= row[48:44];
				exp_wb.wdata <= row[43:12];
				exp_hz.valid <= row[8];
				exp_hz.rt    <= row[4:0];
				idx++;
			end
			@(posedge clk);
			ex_mem    <= '0;
			exp_valid <= 1'b0;
			repeat (3) @(posedge clk);
			done <= 1'b1;
			repeat (2) @(posedge clk);
			if (errors == 0 && checks > 0 && idx > 0) begin
				$display("TEST RESULT: PASS");
			end else begin
				$display("TEST RESULT: FAIL");
			end
			$finish;
		end
	end

endmodule

//--- verification/mem_wb_testdata.txt
// grp_pc4_alures_storedata_hilowdata_rt_dest_memop_ressel_hilowr_regwrite
// _expwe_expwaddr_expwdata_exphzvalid_exphzrt ; group ff ends the table
01_00400000_12345678_00000000_0000000000000000_00_08_0_0_0_1_1_08_12345678_0_00
01_00400010_deadbeef_00000000_0000000000000000_00_1f_0_1_0_1_1_1f_00400014_0_00
01_00400000_cafef00d_00000000_0000000000000000_00_00_0_0_0_1_0_00_00000000_0_00
01_00400000_0badf00d_00000000_0000000000000000_00_05_0_0_0_0_0_05_00000000_0_00
02_00400000_00000000_00000000_89abcdef01234567_00_00_0_0_1_0_0_00_00000000_0_00
02_00400000_00000000_00000000_0000000000000000_00_02_0_2_0_1_1_02_89abcdef_0_00
02_00400000_00000000_00000000_0000000000000000_00_03_0_3_0_1_1_03_01234567_0_00
02_00400000_00000000_00000000_00000000a5a5a5a5_00_00_0_0_2_0_0_00_00000000_0_00
02_00400000_00000000_00000000_0000000000000000_00_04_0_2_0_1_1_04_a5a5a5a5_0_00
02_00400000_00000000_00000000_0000000000000000_00_04_0_3_0_1_1_04_01234567_0_00
02_00400000_00000000_00000000_000000005a5a5a5a_00_06_0_2_3_1_1_06_a5a5a5a5_0_00
02_00400000_00000000_00000000_0000000000000000_00_06_0_3_0_1_1_06_5a5a5a5a_0_00
03_00400000_00000100_8899aabb_0000000000000000_09_00_8_0_0_0_0_00_00000000_0_00
03_00400000_00000100_00000000_0000000000000000_0a_0a_5_0_0_1_1_0a_8899aabb_1_0a
03_00400000_00000101_00000000_0000000000000000_0b_0b_1_0_0_1_1_0b_ffffffaa_1_0b
03_00400000_00000103_00000000_0000000000000000_0c_0c_2_0_0_1_1_0c_00000088_1_0c
03_00400000_00000102_00000000_0000000000000000_0d_0d_3_0_0_1_1_0d_ffff8899_1_0d
03_00400000_00000100_00000000_0000000000000000_0e_0e_4_0_0_1_1_0e_0000aabb_1_0e
03_00400000_00000106_000000c3_0000000000000000_11_00_6_0_0_0_0_00_00000000_0_00
03_00400000_00000104_00007e12_0000000000000000_12_00_7_0_0_0_0_00_00000000_0_00
03_00400000_00000104_00000000_0000000000000000_0f_0f_5_0_0_1_1_0f_00c37e12_1_0f
03_00400000_00000106_00000000_0000000000000000_10_10_1_0_0_1_1_10_ffffffc3_1_10
03_00400000_00000104_00000000_0000000000000000_07_07_3_0_0_1_1_07_00007e12_1_07
04_00400000_00000100_00000000_0000000000000000_14_14_5_0_0_1_1_14_8899aabb_1_14
04_00400000_00000200_11111111_0000000000000000_14_00_8_0_0_0_0_00_00000000_0_00
04_00400000_00000200_00000000_0000000000000000_15_15_5_0_0_1_1_15_8899aabb_1_15
04_00400000_00000204_33333333_0000000000000000_16_00_8_0_0_0_0_00_00000000_0_00
04_00400000_00000204_00000000_0000000000000000_17_17_5_0_0_1_1_17_33333333_1_17
05_00400000_00000000_00000000_0000000000000000_00_00_0_0_0_0_0_00_00000000_0_00
05_00400000_00000200_00000000_0000000000000000_18_18_2_0_0_1_1_18_000000bb_1_18
05_00400000_00000000_00000000_0000000000000000_00_00_0_0_0_0_0_00_00000000_0_00
ff_00000000_00000000_00000000_0000000000000000_00_00_0_0_0_0_0_00_00000000_0_00

//--- sources.f
hdl/mips_isa_pkg.sv
hdl/mips_pipe_pkg.sv
hdl/mem_ctrl.sv
hdl/data_mem.sv
hdl/mem_stage.sv
hdl/wb_stage.sv
hdl/mem_wb_top.sv
verification/tb_clkgen.sv
verification/tb_checker.sv
verification/tb_top.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_top
FILELIST = sources.f
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@! grep -q "TEST RESULT: FAIL" $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
